//--- src/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath width of operands and results
`define EXEC_XLEN 32

// Physical register tag carried with every operand and result
`define EXEC_TAG_W 8

// Entries per reservation station, 2 and 8 also work
`define EXEC_RS_DEPTH 4

// R-type opcode shared by the integer and M-extension ops
`define EXEC_OPC_OP 7'b0110011

// funct7 marking the M-extension group
`define EXEC_F7_MULDIV 7'b0000001

// funct3 codes steered away from the add station
`define EXEC_F3_MUL 3'b000
`define EXEC_F3_DIV 3'b100
`define EXEC_F3_REM 3'b110

`endif

//--- src/exec_pkg.sv
package exec_pkg;

    // Operation code carried with each instruction to its unit
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,   // Signed compare
        SLL = 4'd6,
        SRL = 4'd7,
        MUL = 4'd8,
        DIV = 4'd9,
        REM = 4'd10
    } alu_op_e;

    // Target functional unit of a dispatched instruction
    typedef enum logic [1:0] {
        FU_ADD = 2'd0,
        FU_MUL = 2'd1,
        FU_DIV = 2'd2
    } fu_sel_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,   // Iterations plus sign fix-up
        DIV_DONE = 2'd2    // Holding result until granted
    } div_state_e;

endpackage

//--- src/dispatch_steer.sv
`include "exec_defs.svh"

module dispatch_steer (
    input  logic                  dispatch_valid,
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    input  logic                  alu_src1,
    input  logic                  alu_src2,
    input  logic [`EXEC_XLEN-1:0] operand1,
    input  logic [`EXEC_XLEN-1:0] operand2,
    input  logic [1:0]            operand_valid,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic                  add_full,
    input  logic                  mul_full,
    input  logic                  div_full,
    output logic                  add_rs_on,
    output logic                  mul_rs_on,
    output logic                  div_rs_on,
    output logic                  stall,
    output logic [`EXEC_XLEN-1:0] sel_operand1,
    output logic [`EXEC_XLEN-1:0] sel_operand2,
    output logic [1:0]            sel_valid
);
    import exec_pkg::*;

    fu_sel_e fu_sel;

    always_comb begin
        fu_sel = FU_ADD;
        if (opcode == `EXEC_OPC_OP && funct7 == `EXEC_F7_MULDIV) begin
            case (funct3)
                `EXEC_F3_MUL: fu_sel = FU_MUL;
                `EXEC_F3_DIV, `EXEC_F3_REM: fu_sel = FU_DIV;
                default: fu_sel = FU_ADD;   // MULH and friends run nowhere else
            endcase
        end
    end

    // Stall follows the presented instruction, not the strobe
    assign stall = (fu_sel == FU_MUL) ? mul_full :
                   (fu_sel == FU_DIV) ? div_full : add_full;

    assign add_rs_on = dispatch_valid && !stall && (fu_sel == FU_ADD);
    assign mul_rs_on = dispatch_valid && !stall && (fu_sel == FU_MUL);
    assign div_rs_on = dispatch_valid && !stall && (fu_sel == FU_DIV);

    assign sel_operand1 = alu_src1 ? pc : operand1;
    assign sel_operand2 = alu_src2 ? imm : operand2;
    assign sel_valid    = operand_valid | {alu_src2, alu_src1};   // Substituted operands are ready

endmodule

//--- src/reservation_station.sv
`include "exec_defs.svh"

module reservation_station #(
    parameter int DEPTH = `EXEC_RS_DEPTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   write,
    input  exec_pkg::alu_op_e      alu_op,
    input  logic [`EXEC_XLEN-1:0]  operand1,
    input  logic [`EXEC_XLEN-1:0]  operand2,
    input  logic [1:0]             operand_valid,
    input  logic [`EXEC_TAG_W-1:0] src1_tag,
    input  logic [`EXEC_TAG_W-1:0] src2_tag,
    input  logic [`EXEC_TAG_W-1:0] rd_tag,
    input  logic                   bus_valid,
    input  logic [`EXEC_TAG_W-1:0] bus_tag,
    input  logic [`EXEC_XLEN-1:0]  bus_value,
    input  logic                   unit_ready,
    output logic                   full,
    output logic                   issue_valid,
    output exec_pkg::alu_op_e      issue_op,
    output logic [`EXEC_XLEN-1:0]  issue_a,
    output logic [`EXEC_XLEN-1:0]  issue_b,
    output logic [`EXEC_TAG_W-1:0] issue_tag
);
    import exec_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]       busy, v1, v2;
    logic [DEPTH-1:0]       wake1, wake2;
    alu_op_e                op_q [DEPTH];
    logic [`EXEC_XLEN-1:0]  a_q [DEPTH];
    logic [`EXEC_XLEN-1:0]  b_q [DEPTH];
    logic [`EXEC_TAG_W-1:0] t1_q [DEPTH];
    logic [`EXEC_TAG_W-1:0] t2_q [DEPTH];
    logic [`EXEC_TAG_W-1:0] rd_q [DEPTH];
    logic [IDX_W-1:0]       wr_idx, iss_idx;
    logic                   iss_found;
    logic                   hit1, hit2;

    // Downward scans leave the lowest matching index
    always_comb begin
        wr_idx    = '0;
        iss_idx   = '0;
        iss_found = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            wake1[i] = busy[i] && !v1[i] && bus_valid && (bus_tag == t1_q[i]);
            wake2[i] = busy[i] && !v2[i] && bus_valid && (bus_tag == t2_q[i]);
            if (!busy[i]) wr_idx = IDX_W'(i);
            if (busy[i] && v1[i] && v2[i]) begin
                iss_idx   = IDX_W'(i);
                iss_found = 1'b1;
            end
        end
    end

    assign hit1 = bus_valid && (bus_tag == src1_tag);   // Result broadcast in the dispatch cycle
    assign hit2 = bus_valid && (bus_tag == src2_tag);

    assign full        = &busy;
    assign issue_valid = iss_found && unit_ready;
    assign issue_op    = op_q[iss_idx];
    assign issue_a     = a_q[iss_idx];
    assign issue_b     = b_q[iss_idx];
    assign issue_tag   = rd_q[iss_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            v1   <= '0;
            v2   <= '0;
        end else begin
            v1 <= v1 | wake1;
            v2 <= v2 | wake2;
            if (issue_valid) busy[iss_idx] <= 1'b0;
            if (write && !full) begin
                busy[wr_idx] <= 1'b1;
                v1[wr_idx]   <= operand_valid[0] || hit1;
                v2[wr_idx]   <= operand_valid[1] || hit2;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (wake1[i]) a_q[i] <= bus_value;
            if (wake2[i]) b_q[i] <= bus_value;
        end
        if (write && !full) begin
            op_q[wr_idx] <= alu_op;
            a_q[wr_idx]  <= (!operand_valid[0] && hit1) ? bus_value : operand1;
            b_q[wr_idx]  <= (!operand_valid[1] && hit2) ? bus_value : operand2;
            t1_q[wr_idx] <= src1_tag;
            t2_q[wr_idx] <= src2_tag;
            rd_q[wr_idx] <= rd_tag;
        end
    end

    assert property (@(posedge clk) disable iff (reset) write |-> !full)
        else $error("write into a full reservation station");

endmodule

//--- src/int_alu.sv
`include "exec_defs.svh"

module int_alu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  exec_pkg::alu_op_e      issue_op,
    input  logic [`EXEC_XLEN-1:0]  issue_a,
    input  logic [`EXEC_XLEN-1:0]  issue_b,
    input  logic [`EXEC_TAG_W-1:0] issue_tag,
    input  logic                   grant,
    output logic                   ready,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] done_tag,
    output logic [`EXEC_XLEN-1:0]  done_value
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] result;

    always_comb begin
        case (issue_op)
            ADD: result = issue_a + issue_b;
            SUB: result = issue_a - issue_b;
            AND: result = issue_a & issue_b;
            OR:  result = issue_a | issue_b;
            XOR: result = issue_a ^ issue_b;
            SLT: result = {{(`EXEC_XLEN - 1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
            SLL: result = issue_a << issue_b[4:0];
            SRL: result = issue_a >> issue_b[4:0];
            default: result = '0;
        endcase
    end

    assign ready = !done || grant;   // Output register frees on grant

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (issue_valid && ready) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && ready) begin
            done_tag   <= issue_tag;
            done_value <= result;
        end
    end

endmodule

//--- src/mul_pipe.sv
`include "exec_defs.svh"

module mul_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  logic [`EXEC_XLEN-1:0]  issue_a,
    input  logic [`EXEC_XLEN-1:0]  issue_b,
    input  logic [`EXEC_TAG_W-1:0] issue_tag,
    input  logic                   grant,
    output logic                   ready,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] done_tag,
    output logic [`EXEC_XLEN-1:0]  done_value
);
    logic                   s1_v, s2_v;
    logic [`EXEC_XLEN-1:0]  s1_a, s1_b, s2_p;
    logic [`EXEC_TAG_W-1:0] s1_tag, s2_tag;

    assign ready = !done || grant;   // Whole pipe moves together

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_v <= 1'b0;
            s2_v <= 1'b0;
            done <= 1'b0;
        end else if (ready) begin
            s1_v <= issue_valid;
            s2_v <= s1_v;
            done <= s2_v;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            s1_a       <= issue_a;
            s1_b       <= issue_b;
            s1_tag     <= issue_tag;
            s2_p       <= `EXEC_XLEN'($signed(s1_a) * $signed(s1_b));   // Low half only
            s2_tag     <= s1_tag;
            done_value <= s2_p;
            done_tag   <= s2_tag;
        end
    end

endmodule

//--- src/div_iter.sv
`include "exec_defs.svh"

module div_iter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  exec_pkg::alu_op_e      issue_op,
    input  logic [`EXEC_XLEN-1:0]  issue_a,
    input  logic [`EXEC_XLEN-1:0]  issue_b,
    input  logic [`EXEC_TAG_W-1:0] issue_tag,
    input  logic                   grant,
    output logic                   ready,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] done_tag,
    output logic [`EXEC_XLEN-1:0]  done_value
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(`EXEC_XLEN) + 1;
    localparam int MSB   = `EXEC_XLEN - 1;

    div_state_e            state;
    logic [CNT_W-1:0]      cnt;
    logic [`EXEC_XLEN-1:0] quo, rem, dvs;
    logic [`EXEC_XLEN:0]   shifted, diff;
    logic                  neg_a, neg_b, div_zero;
    alu_op_e               op_q;

    assign shifted = {rem, quo[MSB]};
    assign diff    = shifted - {1'b0, dvs};
    assign ready   = (state == DIV_IDLE);
    assign done    = (state == DIV_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: if (issue_valid) state <= DIV_RUN;
                DIV_RUN:  if (cnt == CNT_W'(`EXEC_XLEN)) state <= DIV_DONE;
                DIV_DONE: if (grant) state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
            cnt <= (state == DIV_RUN) ? cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && issue_valid) begin   // Load magnitudes
            quo      <= issue_a[MSB] ? -issue_a : issue_a;
            dvs      <= issue_b[MSB] ? -issue_b : issue_b;
            rem      <= '0;
            neg_a    <= issue_a[MSB];
            neg_b    <= issue_b[MSB];
            div_zero <= (issue_b == '0);
            op_q     <= issue_op;
            done_tag <= issue_tag;
        end else if (state == DIV_RUN && cnt == CNT_W'(`EXEC_XLEN)) begin
            // Most negative over -1 lands on the dividend without a special case
            if (op_q == REM) begin
                done_value <= neg_a ? -rem : rem;
            end else begin
                done_value <= div_zero ? '1 : ((neg_a ^ neg_b) ? -quo : quo);
            end
        end else if (state == DIV_RUN) begin
            if (!diff[`EXEC_XLEN]) begin
                rem <= diff[MSB:0];
                quo <= {quo[MSB-1:0], 1'b1};
            end else begin
                rem <= shifted[MSB:0];
                quo <= {quo[MSB-1:0], 1'b0};
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) issue_valid |-> state == DIV_IDLE)
        else $error("divide issued while busy");

endmodule

//--- src/result_bus_arbiter.sv
`include "exec_defs.svh"

module result_bus_arbiter (
    input  logic                   alu_done,
    input  logic [`EXEC_TAG_W-1:0] alu_tag,
    input  logic [`EXEC_XLEN-1:0]  alu_value,
    input  logic                   mul_done,
    input  logic [`EXEC_TAG_W-1:0] mul_tag,
    input  logic [`EXEC_XLEN-1:0]  mul_value,
    input  logic                   div_done,
    input  logic [`EXEC_TAG_W-1:0] div_tag,
    input  logic [`EXEC_XLEN-1:0]  div_value,
    output logic                   alu_grant,
    output logic                   mul_grant,
    output logic                   div_grant,
    output logic                   bus_valid,
    output logic [`EXEC_TAG_W-1:0] bus_tag,
    output logic [`EXEC_XLEN-1:0]  bus_value
);
    // Slowest unit first so the long divide never waits
    assign div_grant = div_done;
    assign mul_grant = mul_done && !div_done;
    assign alu_grant = alu_done && !div_done && !mul_done;

    assign bus_valid = alu_done || mul_done || div_done;

    always_comb begin
        if (div_grant) begin
            bus_tag   = div_tag;
            bus_value = div_value;
        end else if (mul_grant) begin
            bus_tag   = mul_tag;
            bus_value = mul_value;
        end else begin
            bus_tag   = alu_tag;
            bus_value = alu_value;
        end
    end

endmodule

//--- src/exec_cluster.sv
`include "exec_defs.svh"

module exec_cluster (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  logic [6:0]             opcode,
    input  logic [2:0]             funct3,
    input  logic [6:0]             funct7,
    input  exec_pkg::alu_op_e      alu_op,
    input  logic [`EXEC_XLEN-1:0]  operand1,
    input  logic [`EXEC_XLEN-1:0]  operand2,
    input  logic [`EXEC_TAG_W-1:0] src1_tag,
    input  logic [`EXEC_TAG_W-1:0] src2_tag,
    input  logic [1:0]             operand_valid,
    input  logic [`EXEC_XLEN-1:0]  imm,
    input  logic [`EXEC_XLEN-1:0]  pc,
    input  logic                   alu_src1,
    input  logic                   alu_src2,
    input  logic [`EXEC_TAG_W-1:0] rd_tag,
    output logic                   stall,
    output logic                   result_valid,
    output logic [`EXEC_TAG_W-1:0] result_tag,
    output logic [`EXEC_XLEN-1:0]  result_value
);
    import exec_pkg::*;

    logic                   add_rs_on, mul_rs_on, div_rs_on;
    logic                   add_full, mul_full, div_full;
    logic [`EXEC_XLEN-1:0]  sel_operand1, sel_operand2;
    logic [1:0]             sel_valid;
    logic                   add_iv, mul_iv, div_iv;
    alu_op_e                add_op, div_op;
    logic [`EXEC_XLEN-1:0]  add_a, add_b, mul_a, mul_b, div_a, div_b;
    logic [`EXEC_TAG_W-1:0] add_tag, mul_tag, div_tag;
    logic                   alu_ready, mul_ready, div_ready;
    logic                   alu_done, mul_done, div_done;
    logic [`EXEC_TAG_W-1:0] alu_dtag, mul_dtag, div_dtag;
    logic [`EXEC_XLEN-1:0]  alu_dval, mul_dval, div_dval;
    logic                   alu_grant, mul_grant, div_grant;

    dispatch_steer steer_i (
        .dispatch_valid, .opcode, .funct3, .funct7, .alu_src1, .alu_src2,
        .operand1, .operand2, .operand_valid, .imm, .pc,
        .add_full, .mul_full, .div_full, .add_rs_on, .mul_rs_on, .div_rs_on,
        .stall, .sel_operand1, .sel_operand2, .sel_valid
    );

    reservation_station add_rs_i (
        .clk, .reset, .write(add_rs_on), .alu_op, .operand1(sel_operand1),
        .operand2(sel_operand2), .operand_valid(sel_valid), .src1_tag, .src2_tag, .rd_tag,
        .bus_valid(result_valid), .bus_tag(result_tag), .bus_value(result_value),
        .unit_ready(alu_ready), .full(add_full), .issue_valid(add_iv), .issue_op(add_op),
        .issue_a(add_a), .issue_b(add_b), .issue_tag(add_tag)
    );

    reservation_station mul_rs_i (
        .clk, .reset, .write(mul_rs_on), .alu_op, .operand1(sel_operand1),
        .operand2(sel_operand2), .operand_valid(sel_valid), .src1_tag, .src2_tag, .rd_tag,
        .bus_valid(result_valid), .bus_tag(result_tag), .bus_value(result_value),
        .unit_ready(mul_ready), .full(mul_full), .issue_valid(mul_iv), .issue_op(),
        .issue_a(mul_a), .issue_b(mul_b), .issue_tag(mul_tag)
    );

    reservation_station div_rs_i (
        .clk, .reset, .write(div_rs_on), .alu_op, .operand1(sel_operand1),
        .operand2(sel_operand2), .operand_valid(sel_valid), .src1_tag, .src2_tag, .rd_tag,
        .bus_valid(result_valid), .bus_tag(result_tag), .bus_value(result_value),
        .unit_ready(div_ready), .full(div_full), .issue_valid(div_iv), .issue_op(div_op),
        .issue_a(div_a), .issue_b(div_b), .issue_tag(div_tag)
    );

    int_alu alu_i (
        .clk, .reset, .issue_valid(add_iv), .issue_op(add_op), .issue_a(add_a),
        .issue_b(add_b), .issue_tag(add_tag), .grant(alu_grant), .ready(alu_ready),
        .done(alu_done), .done_tag(alu_dtag), .done_value(alu_dval)
    );

    mul_pipe mul_i (
        .clk, .reset, .issue_valid(mul_iv), .issue_a(mul_a), .issue_b(mul_b),
        .issue_tag(mul_tag), .grant(mul_grant), .ready(mul_ready),
        .done(mul_done), .done_tag(mul_dtag), .done_value(mul_dval)
    );

    div_iter div_i (
        .clk, .reset, .issue_valid(div_iv), .issue_op(div_op), .issue_a(div_a),
        .issue_b(div_b), .issue_tag(div_tag), .grant(div_grant), .ready(div_ready),
        .done(div_done), .done_tag(div_dtag), .done_value(div_dval)
    );

    result_bus_arbiter arb_i (
        .alu_done, .alu_tag(alu_dtag), .alu_value(alu_dval),
        .mul_done, .mul_tag(mul_dtag), .mul_value(mul_dval),
        .div_done, .div_tag(div_dtag), .div_value(div_dval),
        .alu_grant, .mul_grant, .div_grant,
        .bus_valid(result_valid), .bus_tag(result_tag), .bus_value(result_value)
    );

    // Upstream must hold the instruction while stalled
    assert property (@(posedge clk) disable iff (reset) dispatch_valid |-> !stall)
        else $error("dispatch dropped while stalled");

endmodule

//--- verification/exec_cluster_tb.sv
`include "exec_defs.svh"

module exec_cluster_tb;
    import exec_pkg::*;

    localparam logic [6:0] opc_op    = `EXEC_OPC_OP;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        alu_op_e                op;
        logic [`EXEC_XLEN-1:0]  a;
        logic [`EXEC_XLEN-1:0]  b;
        logic [1:0]             valid;
        logic [`EXEC_TAG_W-1:0] s1;
        logic [`EXEC_TAG_W-1:0] s2;
        logic [`EXEC_TAG_W-1:0] rd;
        logic                   src1;
        logic                   src2;
        logic [`EXEC_XLEN-1:0]  imm;
        logic                   rnd;   // Operands come from the LFSR
    } test_t;

    logic                   clk, reset, dispatch_valid;
    logic [6:0]             opcode, funct7;
    logic [2:0]             funct3;
    alu_op_e                alu_op;
    logic [`EXEC_XLEN-1:0]  operand1, operand2, imm, pc;
    logic [`EXEC_TAG_W-1:0] src1_tag, src2_tag, rd_tag;
    logic [1:0]             operand_valid;
    logic                   alu_src1, alu_src2;
    logic                   stall, result_valid;
    logic [`EXEC_TAG_W-1:0] result_tag;
    logic [`EXEC_XLEN-1:0]  result_value;

    test_t                 tests [$];
    string                 names [$];
    logic [`EXEC_XLEN-1:0] exp_val [256];
    string                 exp_name [256];
    bit                    pend [256];
    int                    dispatched = 0;
    int                    returned = 0;
    bit                    stall_seen = 1'b0;
    logic [31:0]           lfsr_q = 32'd39;

    exec_cluster dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output logic [`EXEC_XLEN-1:0] w);
        for (int i = 0; i < `EXEC_XLEN; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i] = lfsr_q[0];
        end
    endtask

    // RISC-V M and base integer semantics
    function automatic logic [31:0] ref_result(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] prod;
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL: return a << b[4:0];
            SRL: return a >> b[4:0];
            MUL: return prod[31:0];
            DIV: begin
                if (b == 32'd0) return '1;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return $signed(a) / $signed(b);
            end
            REM: begin
                if (b == 32'd0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
                return $signed(a) % $signed(b);
            end
            default: return 32'd0;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("** Error: %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    task automatic add_entry(input string name, input logic [6:0] opc, input int f3,
                             input int f7, input alu_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input int valid, input int s1, input int s2,
                             input int rd, input int src1, input int src2,
                             input logic [31:0] imm_v, input int rnd);
        test_t t;
        t.opcode = opc;
        t.funct3 = 3'(f3);
        t.funct7 = 7'(f7);
        t.op     = op;
        t.a      = a;
        t.b      = b;
        t.valid  = 2'(valid);
        t.s1     = `EXEC_TAG_W'(s1);
        t.s2     = `EXEC_TAG_W'(s2);
        t.rd     = `EXEC_TAG_W'(rd);
        t.src1   = (src1 != 0);
        t.src2   = (src2 != 0);
        t.imm    = imm_v;
        t.rnd    = (rnd != 0);
        tests.push_back(t);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_entry("add",       opc_op, 0, 0,  ADD, 5, 7, 3, 0, 0, 1, 0, 0, 0, 0);
        add_entry("sub",       opc_op, 0, 32, SUB, 5, 7, 3, 0, 0, 2, 0, 0, 0, 0);
        add_entry("and",       opc_op, 7, 0,  AND, 32'hf0f0_1234, 32'h0ff0_ff00, 3, 0, 0, 3,
                  0, 0, 0, 0);
        add_entry("or",        opc_op, 6, 0,  OR, 32'h1200_0034, 32'h0056_7800, 3, 0, 0, 4,
                  0, 0, 0, 0);
        add_entry("xor",       opc_op, 4, 0,  XOR, 32'hffff_0000, 32'h0f0f_0f0f, 3, 0, 0, 5,
                  0, 0, 0, 0);
        add_entry("slt_neg",   opc_op, 2, 0,  SLT, 32'h8000_0000, 1, 3, 0, 0, 6, 0, 0, 0, 0);
        add_entry("slt_pos",   opc_op, 2, 0,  SLT, 7, -3, 3, 0, 0, 7, 0, 0, 0, 0);
        add_entry("sll_wrap",  opc_op, 1, 0,  SLL, 3, 33, 3, 0, 0, 8, 0, 0, 0, 0);
        add_entry("srl",       opc_op, 5, 0,  SRL, 32'h8000_0000, 31, 3, 0, 0, 9, 0, 0, 0, 0);
        add_entry("add_rnd",   opc_op, 0, 0,  ADD, 0, 0, 3, 0, 0, 10, 0, 0, 0, 1);
        add_entry("sub_rnd",   opc_op, 0, 32, SUB, 0, 0, 3, 0, 0, 11, 0, 0, 0, 1);
        add_entry("and_rnd",   opc_op, 7, 0,  AND, 0, 0, 3, 0, 0, 12, 0, 0, 0, 1);
        add_entry("or_rnd",    opc_op, 6, 0,  OR, 0, 0, 3, 0, 0, 13, 0, 0, 0, 1);
        add_entry("xor_rnd",   opc_op, 4, 0,  XOR, 0, 0, 3, 0, 0, 14, 0, 0, 0, 1);
        add_entry("slt_rnd",   opc_op, 2, 0,  SLT, 0, 0, 3, 0, 0, 15, 0, 0, 0, 1);
        add_entry("sll_rnd",   opc_op, 1, 0,  SLL, 0, 0, 3, 0, 0, 16, 0, 0, 0, 1);
        add_entry("srl_rnd",   opc_op, 5, 0,  SRL, 0, 0, 3, 0, 0, 17, 0, 0, 0, 1);
        // Immediate and pc operands replace a stale register value
        add_entry("addi",      opc_imm, 0, 0, ADD, 100, 32'hdead_beef, 1, 0, 0, 18, 0, 1, -16, 0);
        add_entry("xori_f7",   opc_imm, 4, 1, XOR, 32'h00ff_00ff, 32'hdead_beef, 1, 0, 0, 19,
                  0, 1, 32'h0f0f_0f0f, 0);
        add_entry("auipc",     opc_auipc, 0, 0, ADD, 32'hdead_beef, 32'h0001_0000, 2, 0, 0, 20,
                  1, 0, 0, 0);
        add_entry("mul",       opc_op, 0, 1, MUL, 6, 7, 3, 0, 0, 21, 0, 0, 0, 0);
        add_entry("mul_neg",   opc_op, 0, 1, MUL, -7, 6, 3, 0, 0, 22, 0, 0, 0, 0);
        add_entry("mul_big",   opc_op, 0, 1, MUL, 32'h7fff_ffff, 32'h7fff_ffff, 3, 0, 0, 23,
                  0, 0, 0, 0);
        add_entry("mul_rnd_a", opc_op, 0, 1, MUL, 0, 0, 3, 0, 0, 24, 0, 0, 0, 1);
        add_entry("mul_rnd_b", opc_op, 0, 1, MUL, 0, 0, 3, 0, 0, 25, 0, 0, 0, 1);
        add_entry("mul_rnd_c", opc_op, 0, 1, MUL, 0, 0, 3, 0, 0, 26, 0, 0, 0, 1);
        add_entry("div",       opc_op, 4, 1, DIV, 100, 7, 3, 0, 0, 27, 0, 0, 0, 0);
        add_entry("rem_neg",   opc_op, 6, 1, REM, -100, 7, 3, 0, 0, 28, 0, 0, 0, 0);
        add_entry("div_neg",   opc_op, 4, 1, DIV, 100, -7, 3, 0, 0, 29, 0, 0, 0, 0);
        add_entry("div_zero",  opc_op, 4, 1, DIV, 1234, 0, 3, 0, 0, 30, 0, 0, 0, 0);
        add_entry("rem_zero",  opc_op, 6, 1, REM, -1234, 0, 3, 0, 0, 31, 0, 0, 0, 0);
        add_entry("div_ovf",   opc_op, 4, 1, DIV, 32'h8000_0000, -1, 3, 0, 0, 32, 0, 0, 0, 0);
        add_entry("rem_ovf",   opc_op, 6, 1, REM, 32'h8000_0000, -1, 3, 0, 0, 33, 0, 0, 0, 0);
        add_entry("div_rnd",   opc_op, 4, 1, DIV, 0, 0, 3, 0, 0, 34, 0, 0, 0, 1);
        add_entry("rem_rnd",   opc_op, 6, 1, REM, 0, 0, 3, 0, 0, 35, 0, 0, 0, 1);
        // Consumers go out before their slow producers finish
        add_entry("dep_mul",   opc_op, 0, 1, MUL, 3, 5, 3, 0, 0, 40, 0, 0, 0, 0);
        add_entry("dep_add",   opc_op, 0, 0, ADD, 10, 32'hdead_beef, 1, 0, 40, 41, 0, 0, 0, 0);
        add_entry("dep_div",   opc_op, 4, 1, DIV, 1000, -3, 3, 0, 0, 42, 0, 0, 0, 0);
        add_entry("dep_sub",   opc_op, 0, 32, SUB, 32'hdead_beef, 1, 2, 42, 0, 43, 0, 0, 0, 0);
        add_entry("dep_both",  opc_op, 0, 0, ADD, 32'hdead_beef, 32'hdead_beef, 0, 42, 42, 44,
                  0, 0, 0, 0);
        for (int i = 0; i < 7; i++) begin   // Burst deeper than the divide station
            add_entry($sformatf("burst_%0d", i), opc_op, (i % 2 != 0) ? 6 : 4, 1,
                      (i % 2 != 0) ? REM : DIV, 0, 0, 3, 0, 0, 50 + i, 0, 0, 0, 1);
        end
        add_entry("tail_add",  opc_op, 0, 0, ADD, 1, 2, 3, 0, 0, 60, 0, 0, 0, 0);
    endtask

    task automatic apply_entry(input int idx);
        test_t                 t;
        logic [`EXEC_XLEN-1:0] ra, rb, a_eff, b_eff, pc_val;
        t = tests[idx];
        pc_val = 32'h0000_1000 + 32'(idx * 4);
        if (t.rnd) begin
            draw_word(ra);
            draw_word(rb);
            t.a = ra;
            t.b = rb;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
        opcode         = t.opcode;
        funct3         = t.funct3;
        funct7         = t.funct7;
        alu_op         = t.op;
        operand1       = t.a;
        operand2       = t.b;
        operand_valid  = t.valid;
        src1_tag       = t.s1;
        src2_tag       = t.s2;
        rd_tag         = t.rd;
        alu_src1       = t.src1;
        alu_src2       = t.src2;
        imm            = t.imm;
        pc             = pc_val;
        @(negedge clk);
        while (stall) begin   // Stall reflects the presented instruction
            stall_seen = 1'b1;
            @(negedge clk);
        end
        a_eff = t.src1 ? pc_val : (t.valid[0] ? t.a : exp_val[t.s1]);
        b_eff = t.src2 ? t.imm : (t.valid[1] ? t.b : exp_val[t.s2]);
        exp_val[t.rd]  = ref_result(t.op, a_eff, b_eff);
        exp_name[t.rd] = names[idx];
        pend[t.rd]     = 1'b1;
        dispatched++;
        dispatch_valid = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (!pend[result_tag]) begin
                fail_run($sformatf("result for tag %0d was never dispatched or came twice",
                                   result_tag));
            end else begin
                check_value(exp_name[result_tag], exp_val[result_tag], result_value);
                pend[result_tag] = 1'b0;
                returned++;
            end
        end
    end

    initial begin
        @(negedge reset);
        repeat (tests.size() * 40 + 200) @(posedge clk);
        fail_run($sformatf("watchdog expired with %0d results still missing",
                           dispatched - returned));
    end

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        opcode         = '0;
        funct3         = '0;
        funct7         = '0;
        alu_op         = ADD;
        operand1       = '0;
        operand2       = '0;
        operand_valid  = '0;
        src1_tag       = '0;
        src2_tag       = '0;
        rd_tag         = '0;
        imm            = '0;
        pc             = '0;
        alu_src1       = 1'b0;
        alu_src2       = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            apply_entry(i);
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
        wait (returned == dispatched);
        repeat (4) @(negedge clk);
        if (stall_seen) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("stall never rose although the divide station overflowed");
        end
    end

endmodule

//--- verilog.f
+incdir+src
src/exec_pkg.sv
src/dispatch_steer.sv
src/reservation_station.sv
src/int_alu.sv
src/mul_pipe.sv
src/div_iter.sv
src/result_bus_arbiter.sv
src/exec_cluster.sv
verification/exec_cluster_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := exec_cluster_tb
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
